//--- drm_pkg.sv
package drm_pkg;

	//////////////////////////////
	// Sizes

	localparam int MAX_USERS        = 8;
	localparam int USER_IDX_W       = 4;
	localparam int NUM_BANKS        = 16;
	localparam int LANE_W           = 48;
	localparam int ROW_W            = 11;  // Ping-pong bit plus 10 row bits
	localparam int ADDR_W           = 14;  // Row in [13:4], bank in [3:0]
	localparam int DEMUX_W          = 96;
	localparam int BASE_CALC_CYCLES = 8;

	//////////////////////////////
	// Types

	typedef logic [USER_IDX_W-1:0] user_idx_t;
	typedef logic [ADDR_W-1:0]     buf_addr_t;
	typedef logic [ROW_W-1:0]      row_addr_t;
	typedef logic [LANE_W-1:0]     lane_t;
	typedef logic [NUM_BANKS-1:0]  lane_mask_t;
	typedef logic [DEMUX_W-1:0]    demux_word_t;
	typedef logic [3:0]            qm_t;  // 1, 2, 4, 6 or 8

	// Sizes are RE counts minus one
	typedef struct packed {
		logic [15:0] e0_sz;
		logic [15:0] e1_sz;
		logic [7:0]  e0_num;
		qm_t         qm;
		logic        two_layer;
	} user_cfg_t;

	typedef struct packed {
		logic                         valid;
		row_addr_t                    row;
		logic [$clog2(NUM_BANKS)-1:0] bank_lsb;
		user_idx_t                    idx;
	} wr_req_t;

	typedef enum logic [1:0] {
		BASE_IDLE,
		BASE_ACCUM,
		BASE_LOAD
	} base_state_t;

endpackage

//--- drm_base_addr.sv
`timescale 1ns/1ps

module drm_base_addr
	import drm_pkg::*;
(
	input  logic                      i_core_clk,
	input  logic                      i_rx_rstn,
	input  logic                      i_slot_start,
	input  user_cfg_t [MAX_USERS-1:0] i_user_cfg,
	output buf_addr_t [MAX_USERS-1:0] o_base,
	output logic                      o_base_load
);

	base_state_t                         state;
	logic [$clog2(BASE_CALC_CYCLES)-1:0] step;
	buf_addr_t                           sum;
	buf_addr_t                           e1_round;

	// E1 RE count rounded up to a whole row of banks
	assign e1_round = buf_addr_t'({i_user_cfg[step].e1_sz[15:4] + 12'd1, 4'd0});

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			state  <= BASE_IDLE;
			step   <= '0;
			sum    <= '0;
			o_base <= '0;
		end
		else if (i_slot_start)
		begin
			state <= BASE_ACCUM;  // Restart even mid-accumulation
			step  <= '0;
			sum   <= '0;
		end
		else
		begin
			case (state)
				BASE_ACCUM:
				begin
					o_base[step] <= sum;
					sum          <= sum + e1_round;
					step         <= step + 1'b1;
					if (step == BASE_CALC_CYCLES - 1)
						state <= BASE_LOAD;
				end
				BASE_LOAD:
					state <= BASE_IDLE;
				default:
					state <= BASE_IDLE;
			endcase
		end
	end

	// High nine cycles after slot start, all bases settled
	assign o_base_load = (state == BASE_LOAD);

	assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		o_base_load |=> !o_base_load)
		else $error("base load pulse longer than one cycle");

endmodule

//--- drm_user_tracker.sv
`timescale 1ns/1ps

module drm_user_tracker
	import drm_pkg::*;
(
	input  logic                      i_core_clk,
	input  logic                      i_rx_rstn,
	input  logic                      i_slot_start,
	input  logic                      i_base_load,
	input  buf_addr_t [MAX_USERS-1:0] i_base,
	input  user_cfg_t [MAX_USERS-1:0] i_user_cfg,
	input  logic                      i_strb,
	input  user_idx_t                 i_user_idx,
	output wr_req_t                   o_wr_req,
	output logic [MAX_USERS-1:0]      o_pingpong
);

	buf_addr_t                    re_cnt [MAX_USERS];
	buf_addr_t                    addr   [MAX_USERS];
	logic [7:0]                   cb_cnt [MAX_USERS];
	logic [15:0]                  limit  [MAX_USERS];
	buf_addr_t                    step   [MAX_USERS];
	logic [MAX_USERS-1:0]         in_cb;
	logic [MAX_USERS-1:0]         pingpong;
	logic                         strb_ok;
	logic [$clog2(MAX_USERS)-1:0] sel;

	assign strb_ok = i_strb && (i_user_idx < MAX_USERS);  // Index 8..15 ignored
	assign sel     = i_user_idx[$clog2(MAX_USERS)-1:0];

	always_comb
	begin
		for (int u = 0; u < MAX_USERS; u++)
		begin
			limit[u] = (cb_cnt[u] < i_user_cfg[u].e0_num) ? i_user_cfg[u].e0_sz
			                                              : i_user_cfg[u].e1_sz;
			step[u]  = i_user_cfg[u].two_layer ? buf_addr_t'(2) : buf_addr_t'(1);
			in_cb[u] = ({2'b00, re_cnt[u]} < limit[u]);
		end
	end

	//////////////////////////////
	// RE and code-block counters

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			for (int u = 0; u < MAX_USERS; u++)
			begin
				re_cnt[u] <= '0;
				cb_cnt[u] <= '0;
			end
			pingpong <= '0;
		end
		else if (i_slot_start)
		begin
			// Ping-pong bits carry over into the next slot
			for (int u = 0; u < MAX_USERS; u++)
			begin
				re_cnt[u] <= '0;
				cb_cnt[u] <= '0;
			end
		end
		else if (strb_ok)
		begin
			if (in_cb[sel])
				re_cnt[sel] <= re_cnt[sel] + step[sel];
			else
			begin
				re_cnt[sel]   <= '0;  // Code block complete
				pingpong[sel] <= ~pingpong[sel];
				cb_cnt[sel]   <= cb_cnt[sel] + 8'd1;
			end
		end
	end

	//////////////////////////////
	// Address counters

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			for (int u = 0; u < MAX_USERS; u++)
				addr[u] <= '0;
		end
		else if (i_base_load)
		begin
			for (int u = 0; u < MAX_USERS; u++)
				addr[u] <= i_base[u];
		end
		else if (strb_ok)
		begin
			if (in_cb[sel])
				addr[sel] <= addr[sel] + step[sel];
			else
				addr[sel] <= i_base[sel];  // Next block reuses the base in the other half
		end
	end

	always_comb
	begin
		o_wr_req.valid    = strb_ok;
		o_wr_req.row      = {pingpong[sel], addr[sel][ADDR_W-1:4]};
		o_wr_req.bank_lsb = addr[sel][3:0];
		o_wr_req.idx      = i_user_idx;
	end

	assign o_pingpong = pingpong;

	// Limit can move only at slot start, when the counters clear
	for (genvar u = 0; u < MAX_USERS; u++)
	begin : g_re_chk
		assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
			!i_slot_start |-> ({3'b000, re_cnt[u]} <= ({1'b0, limit[u]} + 17'd1)))
			else $error("user %0d RE count past its limit", u);
	end

endmodule

//--- drm_write_format.sv
`timescale 1ns/1ps

module drm_write_format
	import drm_pkg::*;
(
	input  wr_req_t                   i_wr_req,
	input  user_cfg_t [MAX_USERS-1:0] i_user_cfg,
	input  demux_word_t               i_demux_rx,
	output lane_t [NUM_BANKS-1:0]     o_wr_data,
	output lane_mask_t                o_wr_mask
);

	user_cfg_t cfg;
	lane_t     even_lane;
	lane_t     odd_lane;

	assign cfg = i_user_cfg[i_wr_req.idx[$clog2(MAX_USERS)-1:0]];

	//////////////////////////////
	// Two-layer packing

	// Layer 0 in the low qm*6 bits, layer 1 right above it
	always_comb
	begin
		case (cfg.qm)
			4'd1:
			begin
				even_lane = lane_t'(i_demux_rx[5:0]);
				odd_lane  = lane_t'(i_demux_rx[11:6]);
			end
			4'd2:
			begin
				even_lane = lane_t'(i_demux_rx[11:0]);
				odd_lane  = lane_t'(i_demux_rx[23:12]);
			end
			4'd4:
			begin
				even_lane = lane_t'(i_demux_rx[23:0]);
				odd_lane  = lane_t'(i_demux_rx[47:24]);
			end
			4'd6:
			begin
				even_lane = lane_t'(i_demux_rx[35:0]);
				odd_lane  = lane_t'(i_demux_rx[71:36]);
			end
			4'd8:
			begin
				even_lane = i_demux_rx[47:0];
				odd_lane  = i_demux_rx[95:48];
			end
			default:
			begin
				even_lane = '0;  // Illegal order
				odd_lane  = '0;
			end
		endcase
	end

	always_comb
	begin
		for (int l = 0; l < NUM_BANKS; l++)
		begin
			if (!cfg.two_layer)
				o_wr_data[l] = i_demux_rx[LANE_W-1:0];  // Same word on every lane
			else if ((l % 2) == 1)
				o_wr_data[l] = odd_lane;
			else
				o_wr_data[l] = even_lane;
		end

		if (!i_wr_req.valid)
			o_wr_mask = '0;
		else if (!cfg.two_layer)
			o_wr_mask = lane_mask_t'(1) << i_wr_req.bank_lsb;
		else
			o_wr_mask = lane_mask_t'(2'b11) << {i_wr_req.bank_lsb[3:1], 1'b0};
	end

endmodule

//--- drm_input_buffer.sv
`timescale 1ns/1ps

module drm_input_buffer
	import drm_pkg::*;
(
	input  logic                  i_core_clk,
	input  row_addr_t             i_wr_row,
	input  lane_t [NUM_BANKS-1:0] i_wr_data,
	input  lane_mask_t            i_wr_mask,
	input  row_addr_t             i_rd_row,
	output lane_t [NUM_BANKS-1:0] o_rd_data
);

	//////////////////////////////
	// One memory per bank

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		lane_t mem [0:(1 << ROW_W)-1];
		lane_t rd_q;

		always_ff @(posedge i_core_clk)
		begin
			if (i_wr_mask[b])
				mem[i_wr_row] <= i_wr_data[b];
		end

		// Old data when reading the row written on the same edge
		always_ff @(posedge i_core_clk)
		begin
			rd_q <= mem[i_rd_row];
		end

		assign o_rd_data[b] = rd_q;
	end

endmodule

//--- drm_input_top.sv
`timescale 1ns/1ps

module drm_input_top
	import drm_pkg::*;
(
	input  logic                      i_core_clk,
	input  logic                      i_rx_rstn,
	input  logic                      i_rdm_slot_start,
	input  user_cfg_t [MAX_USERS-1:0] i_user_cfg,
	input  logic                      i_demux_strb,
	input  user_idx_t                 i_demux_user_idx,
	input  demux_word_t               i_demux_rx,
	input  row_addr_t                 i_rd_row,
	output lane_t [NUM_BANKS-1:0]     o_rd_data,
	output logic [MAX_USERS-1:0]      o_pingpong
);

	buf_addr_t [MAX_USERS-1:0] base;
	logic                      base_load;
	wr_req_t                   wr_req;
	lane_t [NUM_BANKS-1:0]     wr_data;
	lane_mask_t                wr_mask;

	//////////////////////////////
	// Address side

	drm_base_addr u_base_addr (
		.i_core_clk   (i_core_clk),
		.i_rx_rstn    (i_rx_rstn),
		.i_slot_start (i_rdm_slot_start),
		.i_user_cfg   (i_user_cfg),
		.o_base       (base),
		.o_base_load  (base_load)
	);

	drm_user_tracker u_user_tracker (
		.i_core_clk   (i_core_clk),
		.i_rx_rstn    (i_rx_rstn),
		.i_slot_start (i_rdm_slot_start),
		.i_base_load  (base_load),
		.i_base       (base),
		.i_user_cfg   (i_user_cfg),
		.i_strb       (i_demux_strb),
		.i_user_idx   (i_demux_user_idx),
		.o_wr_req     (wr_req),
		.o_pingpong   (o_pingpong)
	);

	//////////////////////////////
	// Data side

	drm_write_format u_write_format (
		.i_wr_req     (wr_req),
		.i_user_cfg   (i_user_cfg),
		.i_demux_rx   (i_demux_rx),
		.o_wr_data    (wr_data),
		.o_wr_mask    (wr_mask)
	);

	drm_input_buffer u_input_buffer (
		.i_core_clk   (i_core_clk),
		.i_wr_row     (wr_req.row),
		.i_wr_data    (wr_data),
		.i_wr_mask    (wr_mask),
		.i_rd_row     (i_rd_row),
		.o_rd_data    (o_rd_data)
	);

endmodule

//--- tb_drm_input_top.sv
`timescale 1ns/1ps

module tb_drm_input_top
	import drm_pkg::*;
();

	localparam int RUN_CYCLES = 6 + 31 + 37 + 45 + 35 + 31 + 29;  // Reset plus each test
	localparam int MARGIN     = 100;

	logic                      i_core_clk = 1'b0;
	logic                      i_rx_rstn;
	logic                      i_rdm_slot_start;
	user_cfg_t [MAX_USERS-1:0] i_user_cfg;
	logic                      i_demux_strb;
	user_idx_t                 i_demux_user_idx;
	demux_word_t               i_demux_rx;
	row_addr_t                 i_rd_row;
	lane_t [NUM_BANKS-1:0]     o_rd_data;
	logic [MAX_USERS-1:0]      o_pingpong;

	// Reference model state
	logic [31:0]           lcg_state = 32'h7bd5_44e4;
	lane_t                 shadow  [0:(1 << ROW_W)-1][0:NUM_BANKS-1];
	logic                  written [0:(1 << ROW_W)-1][0:NUM_BANKS-1];
	buf_addr_t             m_base  [MAX_USERS];
	buf_addr_t             m_addr  [MAX_USERS];
	int                    m_re    [MAX_USERS];
	int                    m_cb    [MAX_USERS];
	logic [MAX_USERS-1:0]  pp_model = '0;
	lane_t [NUM_BANKS-1:0] rd_exp, rd_keep, rd_exp_q, rd_keep_q;
	logic                  rd_chk = 1'b0, rd_chk_q = 1'b0, pp_chk_q = 1'b0;
	logic [MAX_USERS-1:0]  pp_exp_q = '0;
	int                    n_checks = 0, n_errors = 0, n_tests = 0, err_mark = 0;

	drm_input_top UUT (.*);

	always #5 i_core_clk = ~i_core_clk;

	//////////////////////////////
	// Checks

	always @(posedge i_core_clk)
	begin
		rd_chk_q  <= rd_chk;
		rd_exp_q  <= rd_exp;
		rd_keep_q <= rd_keep;  // Lanes never written are not compared
		pp_chk_q  <= i_demux_strb;
		pp_exp_q  <= pp_model;
		n_checks  += int'(rd_chk_q) + int'(pp_chk_q);
	end

	assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		rd_chk_q |-> ((o_rd_data & rd_keep_q) == rd_exp_q))
		else
		begin
			n_errors++;
			$display("Error at %0t: o_rd_data = %h, expected %h", $time,
				$sampled(o_rd_data) & $sampled(rd_keep_q), $sampled(rd_exp_q));
		end

	assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		pp_chk_q |-> (o_pingpong == pp_exp_q))
		else
		begin
			n_errors++;
			$display("Error at %0t: o_pingpong = %b, expected %b", $time,
				$sampled(o_pingpong), $sampled(pp_exp_q));
		end

	//////////////////////////////
	// Model

	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic demux_word_t rand_word();
		return {rand32(), rand32(), rand32()};
	endfunction

	function automatic int cur_limit(input int u);
		if (m_cb[u] < int'(i_user_cfg[u].e0_num))
			return int'(i_user_cfg[u].e0_sz);
		return int'(i_user_cfg[u].e1_sz);
	endfunction

	function automatic row_addr_t base_row(input int u, input logic pp, input int off);
		return {pp, m_base[u][ADDR_W-1:4] + 10'(off)};
	endfunction

	task automatic set_user(input int u, input int e0, input int e1, input int num,
		input int qm, input bit two);
		i_user_cfg[u] = {16'(e0), 16'(e1), 8'(num), 4'(qm), two};
	endtask

	task automatic put_lane(input row_addr_t row, input int lane, input lane_t v);
		shadow[row][lane]  = v;
		written[row][lane] = 1'b1;
	endtask

	task automatic model_slot_start();
		buf_addr_t sum;
		sum = '0;
		for (int u = 0; u < MAX_USERS; u++)
		begin
			m_base[u] = sum;
			m_addr[u] = sum;
			m_re[u]   = 0;
			m_cb[u]   = 0;
			sum = sum + buf_addr_t'(((int'(i_user_cfg[u].e1_sz) + 16) / 16) * 16);  // E1 count up to 16s
		end
	endtask

	task automatic apply_model(input user_idx_t idx, input demux_word_t w);
		int          u;
		int          n;
		int          bank;
		row_addr_t   row;
		demux_word_t keep;
		if (idx >= MAX_USERS)
			return;
		u    = int'(idx);
		row  = {pp_model[u], m_addr[u][ADDR_W-1:4]};
		bank = int'(m_addr[u][3:0]);
		if (!i_user_cfg[u].two_layer)
			put_lane(row, bank, w[LANE_W-1:0]);
		else
		begin
			// Two layers side by side with qm*6 bits each
			n    = 6 * int'(i_user_cfg[u].qm);
			keep = (demux_word_t'(1) << n) - demux_word_t'(1);
			if (!(i_user_cfg[u].qm inside {4'd1, 4'd2, 4'd4, 4'd6, 4'd8}))
				keep = '0;
			put_lane(row, bank & ~1, lane_t'(w & keep));
			put_lane(row, bank | 1, lane_t'((w >> n) & keep));
		end
		if (m_re[u] < cur_limit(u))
		begin
			m_re[u]   += i_user_cfg[u].two_layer ? 2 : 1;
			m_addr[u] += i_user_cfg[u].two_layer ? buf_addr_t'(2) : buf_addr_t'(1);
		end
		else
		begin
			m_re[u]     = 0;
			m_addr[u]   = m_base[u];
			pp_model[u] = ~pp_model[u];
			m_cb[u]++;
		end
	endtask

	//////////////////////////////
	// Stimulus

	task automatic strobe(input user_idx_t idx, input demux_word_t w);
		i_demux_strb     = 1'b1;
		i_demux_user_idx = idx;
		i_demux_rx       = w;
		apply_model(idx, w);
		@(negedge i_core_clk);
		i_demux_strb = 1'b0;
	endtask

	task automatic read_row(input row_addr_t row);
		for (int l = 0; l < NUM_BANKS; l++)
		begin
			rd_exp[l]  = written[row][l] ? shadow[row][l] : '0;
			rd_keep[l] = written[row][l] ? '1 : '0;
		end
		i_rd_row = row;
		rd_chk   = 1'b1;
		@(negedge i_core_clk);
		rd_chk = 1'b0;
	endtask

	task automatic start_slot();
		i_rdm_slot_start = 1'b1;
		model_slot_start();
		@(negedge i_core_clk);
		i_rdm_slot_start = 1'b0;
		repeat (10) @(negedge i_core_clk);  // Bases settle before the first strobe
	endtask

	task automatic place_users();
		for (int u = 0; u < MAX_USERS; u++)
			strobe(user_idx_t'(u), rand_word());
		for (int u = 0; u < MAX_USERS; u++)
			read_row(base_row(u, pp_model[u], 0));
	endtask

	task automatic end_test(input string name);
		repeat (3) @(negedge i_core_clk);
		n_tests++;
		$display("Test %0d %s: %s, %0d errors", n_tests, name,
			(n_errors == err_mark) ? "ok" : "FAILED", n_errors - err_mark);
		err_mark = n_errors;
	endtask

	initial
	begin
		int blk_len;
		i_rx_rstn        = 1'b0;
		i_rdm_slot_start = 1'b0;
		i_user_cfg       = '0;
		i_demux_strb     = 1'b0;
		i_demux_user_idx = '0;
		i_demux_rx       = '0;
		i_rd_row         = '0;
		rd_exp           = '0;
		rd_keep          = '0;
		for (int r = 0; r < (1 << ROW_W); r++)
			for (int l = 0; l < NUM_BANKS; l++)
				written[r][l] = 1'b0;
		repeat (5) @(posedge i_core_clk);
		@(negedge i_core_clk);
		i_rx_rstn = 1'b1;

		for (int u = 0; u < MAX_USERS; u++)
			set_user(u, 4 + rand32() % 12, rand32() % 40, 1 + rand32() % 2, 8, 0);
		start_slot();
		place_users();
		end_test("base placement");

		set_user(2, 40, 40, 1, 8, 0);
		start_slot();
		repeat (20) strobe(4'd2, rand_word());
		read_row(base_row(2, pp_model[2], 0));
		read_row(base_row(2, pp_model[2], 1));
		end_test("single-layer fill");

		for (int q = 0; q < 5; q++)
			set_user(q + 1, 31, 31, 1, (q == 0) ? 1 : 2 * q, 1);
		set_user(6, 31, 31, 1, 3, 1);  // Not a legal order
		start_slot();
		for (int u = 1; u < 7; u++)
			repeat (4) strobe(user_idx_t'(u), rand_word());
		for (int u = 1; u < 7; u++)
			read_row(base_row(u, pp_model[u], 0));
		end_test("two-layer packing");

		set_user(0, 3, 5, 2, 8, 0);
		start_slot();
		for (int b = 0; b < 3; b++)
		begin
			blk_len = cur_limit(0) + 1;
			repeat (blk_len) strobe(4'd0, rand_word());
			read_row(base_row(0, 1'b0, 0));
			read_row(base_row(0, 1'b1, 0));
		end
		end_test("code-block wrap");

		i_user_cfg[0].e1_sz = i_user_cfg[0].e1_sz + 16'd32;
		start_slot();
		place_users();
		end_test("new slot");

		repeat (2) strobe(4'd0, rand_word());  // User 0 sits at its limit, a stray strobe wraps it
		for (int k = MAX_USERS; k < 16; k++)
			strobe(user_idx_t'(k), rand_word());
		for (int u = 0; u < MAX_USERS; u++)
		begin
			read_row(base_row(u, 1'b0, 0));
			read_row(base_row(u, 1'b1, 0));
		end
		end_test("ignored index");

		$display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial
	begin
		#((RUN_CYCLES + MARGIN) * 10);
		$display("Timeout: run still going after %0d cycles", RUN_CYCLES + MARGIN);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- drm_input_top.f
drm_pkg.sv
drm_base_addr.sv
drm_user_tracker.sv
drm_write_format.sv
drm_input_buffer.sv
drm_input_top.sv
tb_drm_input_top.sv

//--- Makefile
TOP = tb_drm_input_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f drm_input_top.f -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing -Wall --top-module drm_input_top -f drm_input_top.f

clean:
	rm -rf obj_dir
